// File: dispatch_cfg_pkg.sv
package dispatch_cfg_pkg;

    // Dispatch width and VRF read bandwidth
    localparam int NUM_DP_UOP = 2;
    localparam int NUM_VRF_RD = 4;

    // ROB as seen from dispatch
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);

    // Datapath widths
    localparam int VLEN       = 64;
    localparam int XLEN       = 32;
    localparam int VREG_IDX_W = 5;
    localparam int RD_PORT_W  = $clog2(NUM_VRF_RD);

    // Vector sources of one uop, in read port allocation order
    localparam int NUM_SRC    = 3;
    localparam int SRC_VS2    = 0;
    localparam int SRC_VS1    = 1;
    localparam int SRC_VD     = 2;

    typedef logic [VREG_IDX_W-1:0] vreg_idx_t;
    typedef logic [VLEN-1:0]       vdata_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [RD_PORT_W-1:0]  rd_port_t;
    typedef logic [XLEN-1:0]       xdata_t;

    // One bit per vector source, indexed by SRC_*
    typedef logic [NUM_SRC-1:0]    src_mask_t;

endpackage

// File: dispatch_issue_ctrl.sv
module dispatch_issue_ctrl (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     uop_valid,
    input  dispatch_uop_pkg::uop_t [dispatch_cfg_pkg::NUM_DP_UOP-1:0]   uop,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     stall,
    input  logic                                                        strct_hazard,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     rs_ready_alu,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     rs_ready_lsu,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     rob_ready,
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     rs_valid_alu,
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     rs_valid_lsu,
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     rob_valid,
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                     uop_ready
);

    import dispatch_cfg_pkg::*;
    import dispatch_uop_pkg::*;

    logic [NUM_DP_UOP-1:0] rs_ready;
    logic [NUM_DP_UOP-1:0] slot_ok;
    logic [NUM_DP_UOP-1:0] fire;
    logic                  raw_uop_uop;

    for (genvar i = 0; i < NUM_DP_UOP; i++) begin : gen_slot
        // Ready of the station this uop is headed for
        assign rs_ready[i] = (uop[i].exe_unit == LSU) ? rs_ready_lsu[i] : rs_ready_alu[i];

        assign slot_ok[i]  = uop_valid[i] & ~stall[i] & rs_ready[i] & rob_ready[i];

        assign rs_valid_alu[i] = fire[i] & (uop[i].exe_unit == ALU);
        assign rs_valid_lsu[i] = fire[i] & (uop[i].exe_unit == LSU);
    end

    // Slot 1 reads the register that slot 0 writes in the same cycle
    assign raw_uop_uop = uop[0].vd_valid &
                         ((uop[1].vs1_valid & (uop[1].vs1 == uop[0].vd)) |
                          (uop[1].vs2_valid & (uop[1].vs2 == uop[0].vd)) |
                          (uop[1].vs3_valid & (uop[1].vd  == uop[0].vd)));

    // In order, slot 1 only goes together with slot 0
    assign fire[0] = rst_n & slot_ok[0];
    assign fire[1] = fire[0] & slot_ok[1] & ~strct_hazard & ~raw_uop_uop;

    assign uop_ready = fire;
    assign rob_valid = fire;

    a_in_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        uop_ready[1] |-> uop_ready[0]
    ) else $error("slot 1 accepted without slot 0");

    a_one_station : assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs_valid_alu & rs_valid_lsu) == '0
    ) else $error("uop sent to ALU and LSU at once");

endmodule

// File: dispatch_operand_sel.sv
module dispatch_operand_sel (
    input  dispatch_uop_pkg::raw_info_t                                    raw,
    input  dispatch_uop_pkg::opnd_ports_t                                  ports,
    input  dispatch_cfg_pkg::vdata_t [dispatch_cfg_pkg::NUM_VRF_RD-1:0]    rd_data,
    output dispatch_uop_pkg::operands_t                                    opnds
);

    import dispatch_cfg_pkg::*;
    import dispatch_uop_pkg::*;

    vdata_t vrf_vs1;
    vdata_t vrf_vs2;
    vdata_t vrf_vd;

    // VRF data of the port given to each source
    assign vrf_vs1 = rd_data[ports.vs1];
    assign vrf_vs2 = rd_data[ports.vs2];
    assign vrf_vd  = rd_data[ports.vd];

    // A completed ROB entry is newer than the register file
    assign opnds.vs1 = raw.vs1_hit ? raw.vs1_data : vrf_vs1;
    assign opnds.vs2 = raw.vs2_hit ? raw.vs2_data : vrf_vs2;
    assign opnds.vd  = raw.vd_hit  ? raw.vd_data  : vrf_vd;

endmodule

// File: dispatch_raw_check.sv
module dispatch_raw_check (
    input  dispatch_uop_pkg::uop_t                                     uop,
    input  dispatch_uop_pkg::rob_entry_t [dispatch_cfg_pkg::ROB_DEPTH-1:0] rob_entry,
    output dispatch_uop_pkg::raw_info_t                                raw
);

    import dispatch_cfg_pkg::*;
    import dispatch_uop_pkg::*;

    vreg_idx_t [NUM_SRC-1:0] src_idx;
    src_mask_t               src_rd;
    src_mask_t               found;
    src_mask_t               done;
    src_mask_t               hit;
    vdata_t    [NUM_SRC-1:0] fwd_data;

    // Scan from oldest to youngest so the last match is the youngest writer
    function automatic void rob_lookup(
        input  vreg_idx_t                    idx,
        input  rob_entry_t [ROB_DEPTH-1:0]   entries,
        output logic                         match,
        output logic                         ready,
        output vdata_t                       data
    );
        match = 1'b0;
        ready = 1'b0;
        data  = '0;
        for (int e = 0; e < ROB_DEPTH; e++) begin
            if (entries[e].valid && (entries[e].w_index == idx)) begin
                match = 1'b1;
                ready = entries[e].w_valid;
                data  = entries[e].w_data;
            end
        end
    endfunction

    assign src_idx[SRC_VS2] = uop.vs2;
    assign src_idx[SRC_VS1] = uop.vs1;
    assign src_idx[SRC_VD]  = uop.vd;

    assign src_rd[SRC_VS2]  = uop.vs2_valid;
    assign src_rd[SRC_VS1]  = uop.vs1_valid;
    assign src_rd[SRC_VD]   = uop.vs3_valid;

    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            rob_lookup(src_idx[s], rob_entry, found[s], done[s], fwd_data[s]);
        end
    end

    assign hit = src_rd & found & done;

    assign raw.vs1_hit  = hit[SRC_VS1];
    assign raw.vs1_data = fwd_data[SRC_VS1];
    assign raw.vs2_hit  = hit[SRC_VS2];
    assign raw.vs2_data = fwd_data[SRC_VS2];
    assign raw.vd_hit   = hit[SRC_VD];
    assign raw.vd_data  = fwd_data[SRC_VD];

    // Producer still in flight
    assign raw.stall    = |(src_rd & found & ~done);

endmodule

// File: dispatch_read_alloc.sv
module dispatch_read_alloc (
    input  dispatch_cfg_pkg::src_mask_t                                     need0,
    input  dispatch_cfg_pkg::src_mask_t                                     need1,
    input  dispatch_cfg_pkg::vreg_idx_t [dispatch_cfg_pkg::NUM_SRC-1:0]     idx0,
    input  dispatch_cfg_pkg::vreg_idx_t [dispatch_cfg_pkg::NUM_SRC-1:0]     idx1,
    output dispatch_cfg_pkg::vreg_idx_t [dispatch_cfg_pkg::NUM_VRF_RD-1:0]  rd_index,
    output dispatch_cfg_pkg::rd_port_t  [dispatch_cfg_pkg::NUM_SRC-1:0]     ports0,
    output dispatch_cfg_pkg::rd_port_t  [dispatch_cfg_pkg::NUM_SRC-1:0]     ports1,
    output logic                                                            strct_hazard
);

    import dispatch_cfg_pkg::*;

    // Wide enough for every source of both slots
    logic [2:0] cnt0;
    logic [2:0] cnt_all;

    always_comb begin
        rd_index = '0;
        ports0   = '0;
        ports1   = '0;
        cnt0     = '0;

        // Slot 0 first, vs2 then vs1 then vd
        for (int s = 0; s < NUM_SRC; s++) begin
            if (need0[s]) begin
                ports0[s]                       = rd_port_t'(cnt0);
                rd_index[cnt0[RD_PORT_W-1:0]]   = idx0[s];
                cnt0                            = cnt0 + 3'd1;
            end
        end

        cnt_all = cnt0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (need1[s]) begin
                // Reads past the last port are only counted
                if (cnt_all < 3'(NUM_VRF_RD)) begin
                    ports1[s]                        = rd_port_t'(cnt_all);
                    rd_index[cnt_all[RD_PORT_W-1:0]] = idx1[s];
                end
                cnt_all = cnt_all + 3'd1;
            end
        end
    end

    assign strct_hazard = (cnt_all > 3'(NUM_VRF_RD));

    // Slot 0 alone always fits, so the hazard only ever holds back slot 1
    always_comb begin
        a_slot0_fits : assert (cnt0 <= 3'(NUM_VRF_RD))
            else $error("slot 0 needs %0d read ports", cnt0);
    end

endmodule

// File: dispatch_uop_pkg.sv
package dispatch_uop_pkg;

    import dispatch_cfg_pkg::*;

    // Target reservation station
    typedef enum logic [0:0] {
        ALU = 1'b0,
        LSU = 1'b1
    } exe_unit_e;

    // Uop as delivered by the uop queue
    typedef struct packed {
        exe_unit_e  exe_unit;
        logic [5:0] funct6;
        logic [2:0] funct3;
        logic       vm;
        vreg_idx_t  vs1;
        logic       vs1_valid;
        vreg_idx_t  vs2;
        logic       vs2_valid;
        vreg_idx_t  vd;
        logic       vs3_valid;   // vd is also read as a source
        logic       vd_valid;    // vd is written
        xdata_t     rs1_data;
        logic       rs1_valid;
        logic       last_uop;
    } uop_t;

    typedef struct packed {
        logic      valid;
        vreg_idx_t w_index;
        logic      w_valid;      // result already written back into the ROB
        vdata_t    w_data;
    } rob_entry_t;

    // Result of the ROB lookup for one uop
    typedef struct packed {
        logic   vs1_hit;
        vdata_t vs1_data;
        logic   vs2_hit;
        vdata_t vs2_data;
        logic   vd_hit;
        vdata_t vd_data;
        logic   stall;
    } raw_info_t;

    typedef struct packed {
        rd_port_t vs1;
        rd_port_t vs2;
        rd_port_t vd;
    } opnd_ports_t;

    typedef struct packed {
        vdata_t vs1;
        vdata_t vs2;
        vdata_t vd;
    } operands_t;

    // Reservation station payload, shared by ALU and LSU
    typedef struct packed {
        rob_idx_t   rob_entry;
        logic [5:0] funct6;
        logic [2:0] funct3;
        logic       vm;
        vdata_t     vs1_data;
        logic       vs1_data_valid;
        vdata_t     vs2_data;
        logic       vs2_data_valid;
        vdata_t     vd_data;
        logic       vd_data_valid;
        xdata_t     rs1_data;
        logic       rs1_valid;
    } rs_uop_t;

    typedef struct packed {
        vreg_idx_t w_index;
        logic      w_valid;
        logic      last_uop;
    } rob_push_t;

endpackage

// File: rvv_dispatch.sv
module rvv_dispatch (
    input  logic                                                            clk,
    input  logic                                                            rst_n,
    // Uop queue
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         uop_valid,
    input  dispatch_uop_pkg::uop_t [dispatch_cfg_pkg::NUM_DP_UOP-1:0]       uop,
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         uop_ready,
    // ALU reservation station
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         rs_valid_alu,
    output dispatch_uop_pkg::rs_uop_t [dispatch_cfg_pkg::NUM_DP_UOP-1:0]    rs_alu,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         rs_ready_alu,
    // LSU reservation station
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         rs_valid_lsu,
    output dispatch_uop_pkg::rs_uop_t [dispatch_cfg_pkg::NUM_DP_UOP-1:0]    rs_lsu,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         rs_ready_lsu,
    // ROB
    output logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         rob_valid,
    output dispatch_uop_pkg::rob_push_t [dispatch_cfg_pkg::NUM_DP_UOP-1:0]  rob_push,
    input  logic [dispatch_cfg_pkg::NUM_DP_UOP-1:0]                         rob_ready,
    input  dispatch_cfg_pkg::rob_idx_t                                      rob_index,
    input  dispatch_uop_pkg::rob_entry_t [dispatch_cfg_pkg::ROB_DEPTH-1:0]  rob_entry,
    // VRF, data returns in the same cycle
    output dispatch_cfg_pkg::vreg_idx_t [dispatch_cfg_pkg::NUM_VRF_RD-1:0]  rd_index,
    input  dispatch_cfg_pkg::vdata_t    [dispatch_cfg_pkg::NUM_VRF_RD-1:0]  rd_data
);

    import dispatch_cfg_pkg::*;
    import dispatch_uop_pkg::*;

    raw_info_t   [NUM_DP_UOP-1:0]              raw;
    logic        [NUM_DP_UOP-1:0]              stall;
    src_mask_t   [NUM_DP_UOP-1:0]              need;
    vreg_idx_t   [NUM_DP_UOP-1:0][NUM_SRC-1:0] src_idx;
    rd_port_t    [NUM_DP_UOP-1:0][NUM_SRC-1:0] port_sel;
    opnd_ports_t [NUM_DP_UOP-1:0]              ports;
    operands_t   [NUM_DP_UOP-1:0]              opnds;
    rs_uop_t     [NUM_DP_UOP-1:0]              rs_payload;
    logic                                      strct_hazard;

    for (genvar i = 0; i < NUM_DP_UOP; i++) begin : gen_slot
        dispatch_raw_check u_raw_check (
            .uop       (uop[i]),
            .rob_entry (rob_entry),
            .raw       (raw[i])
        );

        assign stall[i] = raw[i].stall;

        // VRF read requests in allocation order
        assign need[i][SRC_VS2]    = uop[i].vs2_valid;
        assign need[i][SRC_VS1]    = uop[i].vs1_valid;
        assign need[i][SRC_VD]     = uop[i].vs3_valid;
        assign src_idx[i][SRC_VS2] = uop[i].vs2;
        assign src_idx[i][SRC_VS1] = uop[i].vs1;
        assign src_idx[i][SRC_VD]  = uop[i].vd;

        assign ports[i].vs1 = port_sel[i][SRC_VS1];
        assign ports[i].vs2 = port_sel[i][SRC_VS2];
        assign ports[i].vd  = port_sel[i][SRC_VD];

        dispatch_operand_sel u_operand_sel (
            .raw     (raw[i]),
            .ports   (ports[i]),
            .rd_data (rd_data),
            .opnds   (opnds[i])
        );

        // ROB slot wraps with the 3-bit index
        assign rs_payload[i].rob_entry      = rob_index + rob_idx_t'(i);
        assign rs_payload[i].funct6         = uop[i].funct6;
        assign rs_payload[i].funct3         = uop[i].funct3;
        assign rs_payload[i].vm             = uop[i].vm;
        assign rs_payload[i].vs1_data       = opnds[i].vs1;
        assign rs_payload[i].vs1_data_valid = uop[i].vs1_valid;
        assign rs_payload[i].vs2_data       = opnds[i].vs2;
        assign rs_payload[i].vs2_data_valid = uop[i].vs2_valid;
        assign rs_payload[i].vd_data        = opnds[i].vd;
        assign rs_payload[i].vd_data_valid  = uop[i].vs3_valid;
        assign rs_payload[i].rs1_data       = uop[i].rs1_data;
        assign rs_payload[i].rs1_valid      = uop[i].rs1_valid;

        assign rob_push[i].w_index  = uop[i].vd;
        assign rob_push[i].w_valid  = uop[i].vd_valid;
        assign rob_push[i].last_uop = uop[i].last_uop;
    end

    dispatch_read_alloc u_read_alloc (
        .need0        (need[0]),
        .need1        (need[1]),
        .idx0         (src_idx[0]),
        .idx1         (src_idx[1]),
        .rd_index     (rd_index),
        .ports0       (port_sel[0]),
        .ports1       (port_sel[1]),
        .strct_hazard (strct_hazard)
    );

    dispatch_issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .stall        (stall),
        .strct_hazard (strct_hazard),
        .rs_ready_alu (rs_ready_alu),
        .rs_ready_lsu (rs_ready_lsu),
        .rob_ready    (rob_ready),
        .rs_valid_alu (rs_valid_alu),
        .rs_valid_lsu (rs_valid_lsu),
        .rob_valid    (rob_valid),
        .uop_ready    (uop_ready)
    );

    // Both stations see the same payload, the valids pick the target
    assign rs_alu = rs_payload;
    assign rs_lsu = rs_payload;

endmodule

// File: rvv_dispatch_tb.sv
module rvv_dispatch_tb;

    import dispatch_cfg_pkg::*;
    import dispatch_uop_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 10;
    localparam logic [63:0] HASH_SEED  = 64'd79;
    // Expected operand source, values 0 to 7 name a ROB entry
    localparam logic [3:0]  FROM_VRF   = 4'h8;
    localparam logic [3:0]  ANY_DATA   = 4'hF;

    typedef struct packed {
        uop_t       [NUM_DP_UOP-1:0]              uops;
        logic       [NUM_DP_UOP-1:0]              uop_valid;
        rob_idx_t                                 rob_index;
        rob_entry_t [ROB_DEPTH-1:0]               rob;
        logic       [NUM_DP_UOP-1:0]              rdy_alu;
        logic       [NUM_DP_UOP-1:0]              rdy_lsu;
        logic       [NUM_DP_UOP-1:0]              rdy_rob;
        logic       [NUM_DP_UOP-1:0]              exp_ready;
        logic       [NUM_DP_UOP-1:0]              exp_alu;
        logic       [NUM_DP_UOP-1:0]              exp_lsu;
        logic       [NUM_DP_UOP-1:0][NUM_SRC-1:0][3:0] exp_src;
    } row_t;

    logic                                  clk;
    logic                                  rst_n;
    logic       [NUM_DP_UOP-1:0]           uop_valid;
    uop_t       [NUM_DP_UOP-1:0]           uop;
    logic       [NUM_DP_UOP-1:0]           uop_ready;
    logic       [NUM_DP_UOP-1:0]           rs_valid_alu;
    rs_uop_t    [NUM_DP_UOP-1:0]           rs_alu;
    logic       [NUM_DP_UOP-1:0]           rs_ready_alu;
    logic       [NUM_DP_UOP-1:0]           rs_valid_lsu;
    rs_uop_t    [NUM_DP_UOP-1:0]           rs_lsu;
    logic       [NUM_DP_UOP-1:0]           rs_ready_lsu;
    logic       [NUM_DP_UOP-1:0]           rob_valid;
    rob_push_t  [NUM_DP_UOP-1:0]           rob_push;
    logic       [NUM_DP_UOP-1:0]           rob_ready;
    rob_idx_t                              rob_index;
    rob_entry_t [ROB_DEPTH-1:0]            rob_entry;
    vreg_idx_t  [NUM_VRF_RD-1:0]           rd_index;
    vdata_t     [NUM_VRF_RD-1:0]           rd_data;

    row_t table_q[$];
    row_t cur;
    int   errors;
    int   checks;
    int   cycles;
    int   timeout_limit;

    tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.clk(clk));

    rvv_dispatch rvv_dispatch_inst (.*);

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // Register contents are a hash of the register number
    function automatic logic [63:0] vrf_hash(input vreg_idx_t idx);
        logic [63:0] x;
        x = HASH_SEED + 64'(idx) * 64'h9E37_79B9_7F4A_7C15;
        return xorshift64(xorshift64(xorshift64(x)));
    endfunction

    always @(*) begin
        for (int p = 0; p < NUM_VRF_RD; p++) begin
            rd_data[p] = vrf_hash(rd_index[p]);
        end
    end

    // read mask bits are vs2, vs1, vd from bit 0 upwards
    function automatic uop_t make_uop(input exe_unit_e unit, input vreg_idx_t vs2,
                                      input vreg_idx_t vs1, input vreg_idx_t vd,
                                      input src_mask_t rd, input logic vd_wr);
        uop_t u;
        u           = '0;
        u.exe_unit  = unit;
        u.funct6    = {1'b1, vd};
        u.funct3    = vs1[2:0];
        u.vm        = 1'b1;
        u.vs2       = vs2;
        u.vs2_valid = rd[SRC_VS2];
        u.vs1       = vs1;
        u.vs1_valid = rd[SRC_VS1];
        u.vd        = vd;
        u.vs3_valid = rd[SRC_VD];
        u.vd_valid  = vd_wr;
        u.rs1_data  = 32'h1000_0000 | 32'(vs2);
        u.rs1_valid = (unit == LSU);
        u.last_uop  = vd_wr;
        return u;
    endfunction

    function automatic rob_entry_t make_entry(input int e, input vreg_idx_t idx, input logic wv);
        rob_entry_t r;
        r.valid   = 1'b1;
        r.w_index = idx;
        r.w_valid = wv;
        r.w_data  = 64'hF0D0_0000_0000_0000 | (64'(e) << 8) | 64'(idx);
        return r;
    endfunction

    function automatic logic [63:0] expected_operand(input row_t r, input int i, input int s);
        vreg_idx_t idx;
        idx = (s == SRC_VS2) ? r.uops[i].vs2 : (s == SRC_VS1) ? r.uops[i].vs1 : r.uops[i].vd;
        if (r.exp_src[i][s] == FROM_VRF) begin
            return vrf_hash(idx);
        end
        return r.rob[r.exp_src[i][s][2:0]].w_data;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Defaults: both uops valid, all readies high, empty ROB, operands from the VRF
    task automatic start_row();
        cur           = '0;
        cur.uop_valid = '1;
        cur.rdy_alu   = '1;
        cur.rdy_lsu   = '1;
        cur.rdy_rob   = '1;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            for (int s = 0; s < NUM_SRC; s++) begin
                cur.exp_src[i][s] = FROM_VRF;
            end
        end
    endtask

    task automatic add_row(input logic [1:0] ready, input logic [1:0] alu, input logic [1:0] lsu);
        cur.exp_ready = ready;
        cur.exp_alu   = alu;
        cur.exp_lsu   = lsu;
        table_q.push_back(cur);
    endtask

    task automatic apply_row(input row_t r);
        uop_valid    = r.uop_valid;
        uop          = r.uops;
        rob_index    = r.rob_index;
        rob_entry    = r.rob;
        rs_ready_alu = r.rdy_alu;
        rs_ready_lsu = r.rdy_lsu;
        rob_ready    = r.rdy_rob;
    endtask

    task automatic check_row(input int n, input row_t r);
        rs_uop_t     pay;
        src_mask_t   rd;
        logic [63:0] got;
        string       tag;
        string       ptag;
        check_val($sformatf("row %0d uop_ready", n), uop_ready, r.exp_ready);
        check_val($sformatf("row %0d rob_valid", n), rob_valid, r.exp_ready);
        check_val($sformatf("row %0d rs_valid_alu", n), rs_valid_alu, r.exp_alu);
        check_val($sformatf("row %0d rs_valid_lsu", n), rs_valid_lsu, r.exp_lsu);
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            rd   = {r.uops[i].vs3_valid, r.uops[i].vs1_valid, r.uops[i].vs2_valid};
            ptag = $sformatf("row %0d slot %0d", n, i);
            check_val({ptag, " rob_push.w_index"}, rob_push[i].w_index, r.uops[i].vd);
            check_val({ptag, " rob_push.w_valid"}, rob_push[i].w_valid, r.uops[i].vd_valid);
            check_val({ptag, " rob_push.last_uop"}, rob_push[i].last_uop, r.uops[i].last_uop);
            // Both stations carry the payload, only the valids differ
            for (int st = 0; st < 2; st++) begin
                pay = (st == 1) ? rs_lsu[i] : rs_alu[i];
                tag = {ptag, (st == 1) ? " rs_lsu" : " rs_alu"};
                check_val({tag, " rob_entry"}, pay.rob_entry, (int'(r.rob_index) + i) % ROB_DEPTH);
                check_val({tag, " funct6"}, pay.funct6, r.uops[i].funct6);
                check_val({tag, " funct3"}, pay.funct3, r.uops[i].funct3);
                check_val({tag, " vm"}, pay.vm, r.uops[i].vm);
                check_val({tag, " rs1_data"}, pay.rs1_data, r.uops[i].rs1_data);
                check_val({tag, " rs1_valid"}, pay.rs1_valid, r.uops[i].rs1_valid);
                check_val({tag, " data_valid"},
                          {pay.vd_data_valid, pay.vs1_data_valid, pay.vs2_data_valid}, rd);
                for (int s = 0; s < NUM_SRC; s++) begin
                    if (rd[s] && r.exp_src[i][s] != ANY_DATA) begin
                        got = (s == SRC_VS2) ? pay.vs2_data :
                              (s == SRC_VS1) ? pay.vs1_data : pay.vd_data;
                        check_val($sformatf("%s src %0d data", tag, s), got,
                                  expected_operand(r, i, s));
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout: the run did not end within %0d cycles", timeout_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        timeout_limit = RST_CYCLES + 20;
        rst_n         = 1'b0;

        // Independent ALU and LSU uops with 4 reads, then ROB index wraparound
        start_row();
        cur.uops[0]   = make_uop(ALU, 5'd1, 5'd2, 5'd3, 3'b011, 1'b1);
        cur.uops[1]   = make_uop(LSU, 5'd4, 5'd0, 5'd5, 3'b101, 1'b0);
        cur.rob_index = 3'd2;
        add_row(2'b11, 2'b01, 2'b10);
        cur.rob_index = 3'd7;
        add_row(2'b11, 2'b01, 2'b10);

        // Five reads, slot 1 vs1 gets no port
        start_row();
        cur.uops[0]           = make_uop(ALU, 5'd1, 5'd2, 5'd3, 3'b111, 1'b1);
        cur.uops[1]           = make_uop(ALU, 5'd6, 5'd7, 5'd8, 3'b011, 1'b1);
        cur.exp_src[1][SRC_VS1] = ANY_DATA;
        add_row(2'b01, 2'b01, 2'b00);

        // Producer in flight for slot 0, then for slot 1 only
        start_row();
        cur.uops[0]           = make_uop(ALU, 5'd1, 5'd2, 5'd3, 3'b011, 1'b1);
        cur.uops[1]           = make_uop(LSU, 5'd6, 5'd7, 5'd9, 3'b011, 1'b0);
        cur.rob[0]            = make_entry(0, 5'd2, 1'b0);
        cur.exp_src[0][SRC_VS1] = ANY_DATA;
        add_row(2'b00, 2'b00, 2'b00);
        cur.rob[0]            = make_entry(0, 5'd7, 1'b0);
        cur.exp_src[0][SRC_VS1] = FROM_VRF;
        cur.exp_src[1][SRC_VS1] = ANY_DATA;
        add_row(2'b01, 2'b01, 2'b00);

        // Forwarding from a finished entry
        cur.rob                 = '0;
        cur.rob[2]              = make_entry(2, 5'd2, 1'b1);
        cur.rob[4]              = make_entry(4, 5'd12, 1'b0);
        cur.exp_src[0][SRC_VS1] = 4'd2;
        cur.exp_src[1][SRC_VS1] = FROM_VRF;
        add_row(2'b11, 2'b01, 2'b10);

        // Three writers of v6, the youngest has its result
        cur.rob                 = '0;
        cur.rob[1]              = make_entry(1, 5'd6, 1'b1);
        cur.rob[3]              = make_entry(3, 5'd6, 1'b0);
        cur.rob[5]              = make_entry(5, 5'd6, 1'b1);
        cur.exp_src[0][SRC_VS1] = FROM_VRF;
        cur.exp_src[1][SRC_VS2] = 4'd5;
        add_row(2'b11, 2'b01, 2'b10);

        // Slot 1 reads v3 that slot 0 writes
        start_row();
        cur.uops[0] = make_uop(ALU, 5'd1, 5'd2, 5'd3, 3'b011, 1'b1);
        cur.uops[1] = make_uop(LSU, 5'd6, 5'd3, 5'd9, 3'b011, 1'b0);
        add_row(2'b01, 2'b01, 2'b00);

        // Back-pressure cases
        start_row();
        cur.uops[0] = make_uop(ALU, 5'd1, 5'd2, 5'd3, 3'b011, 1'b1);
        cur.uops[1] = make_uop(LSU, 5'd6, 5'd7, 5'd9, 3'b011, 1'b0);
        cur.rdy_alu = 2'b00;
        add_row(2'b00, 2'b00, 2'b00);
        cur.rdy_alu   = 2'b11;
        cur.uop_valid = 2'b10;
        add_row(2'b00, 2'b00, 2'b00);
        cur.uop_valid = 2'b11;
        cur.rdy_rob   = 2'b01;
        add_row(2'b01, 2'b01, 2'b00);

        timeout_limit = timeout_limit + table_q.size();

        // Reset with real traffic on the inputs
        apply_row(table_q[0]);
        for (int c = 0; c < RST_CYCLES; c++) begin
            @(negedge clk);
            #(CLK_PERIOD / 2 - 1);
            check_val("reset uop_ready", uop_ready, '0);
            check_val("reset rob_valid", rob_valid, '0);
            check_val("reset rs_valid_alu", rs_valid_alu, '0);
            check_val("reset rs_valid_lsu", rs_valid_lsu, '0);
        end
        @(negedge clk);
        rst_n = 1'b1;

        foreach (table_q[n]) begin
            @(negedge clk);
            apply_row(table_q[n]);
            #(CLK_PERIOD / 2 - 1);
            check_row(n, table_q[n]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
dispatch_cfg_pkg.sv
dispatch_uop_pkg.sv
dispatch_raw_check.sv
dispatch_read_alloc.sv
dispatch_operand_sel.sv
dispatch_issue_ctrl.sv
rvv_dispatch.sv
tb_clk_gen.sv
rvv_dispatch_tb.sv

// File: tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, first rising edge at half a period
    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule
